/* dl_monitor.f */
src/dl_pkg.sv
src/dl_router.sv
src/header_scan.sv
src/region_select.sv
src/code_assembler.sv
src/dl_monitor.sv
sim/dl_monitor_tb.sv

/* sim/dl_monitor_tb.sv */
`timescale 1ns/1ns

module dl_monitor_tb;

	localparam int HDR_WORDS   = 257;
	// Nine cart files and four cheat groups, one idle cycle after each word
	localparam int TOTAL_WORDS = 9 * HDR_WORDS + 4 * dl_pkg::CODE_WORDS;
	localparam int CYCLE_LIMIT = 2 * TOTAL_WORDS + 300;

	logic                clk_sys = 1'b0;
	logic                sys_reset;
	logic                dl_active_i;
	logic [7:0]          dl_index_i;
	logic                dl_valid_i;
	dl_pkg::dl_word_t    dl_word_i;
	logic                dl_ready_o;
	dl_pkg::region_cfg_t region_cfg_i;
	logic                cart_sms_o;
	logic                region_valid_o;
	dl_pkg::region_t     region_o;
	logic                region_ready_i;
	logic                code_valid_o;
	dl_pkg::cheat_code_t code_o;
	logic                code_ready_i;
	logic                code_clear_o;

	dl_pkg::region_t     regions_seen[$];
	dl_pkg::cheat_code_t codes_seen[$];
	int                  clears_seen = 0;
	int                  cycles = 0;

	dl_monitor dut (.*);

	always #10 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Output side monitor and timeout

	// Outputs watched here are all registered
	always @(posedge clk_sys) begin
		if (!sys_reset) begin
			if (region_valid_o && region_ready_i)
				regions_seen.push_back(region_o);
			if (code_valid_o && code_ready_i)
				codes_seen.push_back(code_o);
			if (code_clear_o)
				clears_seen++;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Timeout: tests still running after %0d cycles", cycles);
		end
	end

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	function automatic logic [15:0] fill_word(input logic [24:0] a);
		return a[15:0] ^ {a[24:16], 7'h35};
	endfunction

	// First flagged region in the priority order, else the order's leading region
	function automatic dl_pkg::region_t resolve_region(input logic [1:0] prio,
		input logic [2:0] jue);
		logic [5:0]      order;
		logic [2:0]      present;
		logic [1:0]      r;
		logic            found;
		dl_pkg::region_t pick;
		case (prio)
			2'd0: order = {dl_pkg::US, dl_pkg::EU, dl_pkg::JP};
			2'd1: order = {dl_pkg::EU, dl_pkg::US, dl_pkg::JP};
			2'd2: order = {dl_pkg::US, dl_pkg::JP, dl_pkg::EU};
			default: order = {dl_pkg::JP, dl_pkg::US, dl_pkg::EU};
		endcase
		// Indexed by region code, JP 0 US 1 EU 2
		present = {jue[0], jue[1], jue[2]};
		pick    = dl_pkg::region_t'(order[5:4]);
		found   = 1'b0;
		for (int k = 0; k < 3; k++) begin
			r = order[5 - 2 * k -: 2];
			if (!found && present[r]) begin
				pick  = dl_pkg::region_t'(r);
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stream drivers

	task automatic send_word(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		dl_valid_i     = 1'b1;
		dl_word_i.addr = addr;
		dl_word_i.data = data;
		do
			@(posedge clk_sys);
		while (!dl_ready_o);
		@(negedge clk_sys);
		dl_valid_i = 1'b0;
	endtask

	task automatic start_file(input logic [7:0] index);
		@(negedge clk_sys);
		dl_index_i  = index;
		dl_active_i = 1'b1;
	endtask

	// Idle long enough for the region event after the last word
	task automatic end_file();
		@(negedge clk_sys);
		dl_active_i = 1'b0;
		repeat (3)
			@(negedge clk_sys);
	endtask

	task automatic send_header(input logic [15:0] region_w, input logic [15:0] region2_w);
		logic [24:0] a;
		logic [15:0] d;
		for (int i = 0; i < HDR_WORDS; i++) begin
			a = 25'(2 * i);
			if (a == dl_pkg::HDR_REGION_ADDR)
				d = region_w;
			else if (a == dl_pkg::HDR_REGION2_ADDR)
				d = region2_w;
			else
				d = fill_word(a);
			send_word(a, d);
		end
	endtask

	// Low half first, fields in flags, address, compare, replace order
	task automatic send_code(input logic [24:0] base, input dl_pkg::cheat_code_t c);
		logic [127:0] bits;
		bits = c;
		for (int k = 0; k < dl_pkg::CODE_WORDS; k++)
			send_word(base + 25'(2 * k), bits[(3 - k / 2) * 32 + (k % 2) * 16 +: 16]);
	endtask

	task automatic download_cart(input logic [7:0] index, input logic [1:0] mode,
		input logic [1:0] prio, input logic [15:0] region_w, input logic [15:0] region2_w);
		@(negedge clk_sys);
		region_cfg_i.auto_mode = mode;
		region_cfg_i.prio      = prio;
		start_file(index);
		send_header(region_w, region2_w);
		end_file();
	endtask

	task automatic take_region(output dl_pkg::region_t r);
		while (regions_seen.size() == 0)
			@(negedge clk_sys);
		r = regions_seen.pop_front();
	endtask

	task automatic take_code(output dl_pkg::cheat_code_t c);
		while (codes_seen.size() == 0)
			@(negedge clk_sys);
		c = codes_seen.pop_front();
	endtask

	task automatic cart_case(input logic [1:0] prio, input logic [15:0] region_w,
		input logic [15:0] region2_w, input logic [2:0] jue, input string what);
		dl_pkg::region_t r;
		download_cart(8'h01, 2'd0, prio, region_w, region2_w);
		take_region(r);
		check_value(r, resolve_region(prio, jue), what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_letter_header();
		cart_case(2'd0, {" ", "U"}, {" ", " "}, 3'b010, "letter U, order 0");
		cart_case(2'd3, {" ", "J"}, {" ", "E"}, 3'b101, "letters J and E, order 3");
		cart_case(2'd1, {" ", " "}, {" ", " "}, 3'b000, "no region letters, order 1");
	endtask

	task automatic test_digit_header();
		// Sink stays ready for both carts
		@(negedge clk_sys);
		region_ready_i = 1'b1;
		// 8'h34 gives e 0, u 1, j 0
		cart_case(2'd1, {" ", "4"}, {" ", " "}, 3'b010, "digit 4, order 1");
		// Nibble 1 minus 7 is 4'hA so e only
		cart_case(2'd0, {" ", "A"}, {" ", " "}, 3'b001, "hex A, order 0");
	endtask

	task automatic test_modes();
		dl_pkg::region_t r;
		// Top index bits 2'b10 select EU, header letter ignored
		download_cart(8'h81, 2'd1, 2'd0, {" ", "J"}, {" ", " "});
		take_region(r);
		check_value(r, dl_pkg::EU, "file extension mode, index 0x81");
		check_value(cart_sms_o, 1'b0, "cart_sms_o after MD cart");
		download_cart(8'h01, 2'd2, 2'd0, {" ", "U"}, {" ", " "});
		check_value(regions_seen.size(), 0, "region events with auto mode disabled");
		download_cart({3'b000, dl_pkg::IDX_CART_SMS}, 2'd0, 2'd0, {" ", "U"}, {" ", " "});
		check_value(cart_sms_o, 1'b1, "cart_sms_o after SMS cart");
		check_value(regions_seen.size(), 0, "region events for SMS cart");
	endtask

	task automatic test_cheat_codes();
		dl_pkg::cheat_code_t c0;
		dl_pkg::cheat_code_t c1;
		dl_pkg::cheat_code_t got;
		int                  clears;
		c0     = {$urandom, $urandom, $urandom, $urandom};
		c1     = {$urandom, $urandom, $urandom, $urandom};
		clears = clears_seen;
		start_file(dl_pkg::IDX_CODE);
		send_code(25'h00, c0);
		send_code(25'h10, c1);
		end_file();
		take_code(got);
		check_value(got, c0, "first cheat code");
		take_code(got);
		check_value(got, c1, "second cheat code");
		check_value(clears_seen - clears, 1, "code_clear_o pulses in cheat file");
	endtask

	task automatic test_back_pressure();
		dl_pkg::cheat_code_t c0;
		dl_pkg::cheat_code_t c1;
		dl_pkg::cheat_code_t got;
		dl_pkg::region_t     held;
		dl_pkg::region_t     r;
		c0 = {$urandom, $urandom, $urandom, $urandom};
		c1 = {$urandom, $urandom, $urandom, $urandom};
		@(negedge clk_sys);
		code_ready_i = 1'b0;
		start_file(dl_pkg::IDX_CODE);
		send_code(25'h00, c0);
		fork
			send_code(25'h10, c1);
			begin
				// Closing word of group two meets the held first code
				do
					@(posedge clk_sys);
				while (!(dl_valid_i && dl_word_i.addr == 25'h1E));
				repeat (4) begin
					check_value(dl_ready_o, 1'b0, "dl_ready_o stalled on closing word");
					@(posedge clk_sys);
				end
				check_value(code_valid_o, 1'b1, "first code held while code_ready_i low");
				check_value(code_o, c0, "first code intact while stalled");
				@(negedge clk_sys);
				code_ready_i = 1'b1;
			end
		join
		end_file();
		take_code(got);
		check_value(got, c0, "first code after release");
		take_code(got);
		check_value(got, c1, "second code after release");

		// Region event held off by the sink
		@(negedge clk_sys);
		region_ready_i         = 1'b0;
		region_cfg_i.auto_mode = 2'd0;
		region_cfg_i.prio      = 2'd2;
		start_file(8'h01);
		send_header({" ", "E"}, {" ", " "});
		do
			@(posedge clk_sys);
		while (!region_valid_o);
		held = region_o;
		repeat (5) begin
			@(posedge clk_sys);
			check_value(region_valid_o, 1'b1, "region_valid_o held without ready");
			check_value(region_o, held, "region_o stable while held");
		end
		@(negedge clk_sys);
		region_ready_i = 1'b1;
		take_region(r);
		check_value(r, held, "held region after release");
		check_value(r, resolve_region(2'd2, 3'b001), "letter E, order 2");
		end_file();
	endtask

	initial begin
		void'($urandom(32'h6335_a9d9));
		sys_reset      = 1'b1;
		dl_active_i    = 1'b0;
		dl_index_i     = 8'h00;
		dl_valid_i     = 1'b0;
		dl_word_i      = '0;
		region_cfg_i   = '0;
		region_ready_i = 1'b1;
		code_ready_i   = 1'b1;
		repeat (2)
			@(negedge clk_sys);
		sys_reset = 1'b0;
		check_value(region_valid_o, 1'b0, "region_valid_o after reset");
		check_value(code_valid_o, 1'b0, "code_valid_o after reset");
		check_value(code_clear_o, 1'b0, "code_clear_o after reset");
		check_value(dl_ready_o, 1'b1, "dl_ready_o after reset");
		check_value(cart_sms_o, 1'b0, "cart_sms_o after reset");
		test_letter_header();
		test_digit_header();
		test_modes();
		test_cheat_codes();
		test_back_pressure();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* src/code_assembler.sv */
`timescale 1ns/1ns

module code_assembler (
	input  logic                clk_sys,
	input  logic                sys_reset,
	input  logic                code_start_i,
	input  logic                cart_start_i,
	input  logic                in_valid_i,
	input  dl_pkg::dl_word_t    word_i,
	output logic                in_ready_o,
	output dl_pkg::cheat_code_t code_o,
	output logic                code_valid_o,
	input  logic                code_ready_i,
	output logic                code_clear_o
);

	dl_pkg::cheat_code_t asm_q;
	logic                last_word;
	logic                accept;

	assign last_word = (word_i.addr[3:0] == dl_pkg::CODE_LAST_OFS);

	// Only the closing word has to wait for the held code to drain
	assign in_ready_o = ~(code_valid_o & ~code_ready_i & last_word);
	assign accept     = in_valid_i & in_ready_o;

	////////////////////////////////////////////////////////////////////////////
	// Field staging, low word first

	always_ff @(posedge clk_sys) begin
		if (code_start_i)
			asm_q <= '0;
		if (accept) begin
			case (word_i.addr[3:0])
				4'd0:  asm_q.flags[15:0]    <= word_i.data;
				4'd2:  asm_q.flags[31:16]   <= word_i.data;
				4'd4:  asm_q.address[15:0]  <= word_i.data;
				4'd6:  asm_q.address[31:16] <= word_i.data;
				4'd8:  asm_q.compare[15:0]  <= word_i.data;
				4'd10: asm_q.compare[31:16] <= word_i.data;
				4'd12: asm_q.replace[15:0]  <= word_i.data;
				default: ;
			endcase
		end
	end

	// Completed code goes straight to the output holding register
	always_ff @(posedge clk_sys) begin
		if (accept && last_word) begin
			code_o               <= asm_q;
			code_o.replace[31:16] <= word_i.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			code_valid_o <= 1'b0;
			code_clear_o <= 1'b0;
		end else begin
			// Code table restarts with a new cart or a new cheat file
			code_clear_o <= cart_start_i | (accept && word_i.addr == '0);
			if (accept && last_word)
				code_valid_o <= 1'b1;
			else if (code_ready_i)
				code_valid_o <= 1'b0;
		end
	end

	a_code_held: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		(code_valid_o && !code_ready_i) |=> (code_valid_o && $stable(code_o))
	);

endmodule

/* src/dl_monitor.sv */
`timescale 1ns/1ns

module dl_monitor (
	input  logic                clk_sys,
	input  logic                sys_reset,
	input  logic                dl_active_i,
	input  logic [7:0]          dl_index_i,
	input  logic                dl_valid_i,
	input  dl_pkg::dl_word_t    dl_word_i,
	output logic                dl_ready_o,
	input  dl_pkg::region_cfg_t region_cfg_i,
	output logic                cart_sms_o,
	output logic                region_valid_o,
	output dl_pkg::region_t     region_o,
	input  logic                region_ready_i,
	output logic                code_valid_o,
	output dl_pkg::cheat_code_t code_o,
	input  logic                code_ready_i,
	output logic                code_clear_o
);

	logic               cart_start;
	logic               cart_end;
	logic               cart_wr;
	logic               code_start;
	logic               code_in_valid;
	logic               code_in_ready;
	dl_pkg::hdr_flags_t hdr_flags;
	logic               hdr_ready;

	dl_router u_router (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_index_i),
		.dl_valid_i   (dl_valid_i),
		.dl_word_i    (dl_word_i),
		.dl_ready_o   (dl_ready_o),
		.cart_sms_o   (cart_sms_o),
		.cart_start_o (cart_start),
		.cart_end_o   (cart_end),
		.cart_wr_o    (cart_wr),
		.code_start_o (code_start),
		.code_valid_o (code_in_valid),
		.code_ready_i (code_in_ready)
	);

	header_scan u_header_scan (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.cart_start_i (cart_start),
		.cart_end_i   (cart_end),
		.cart_wr_i    (cart_wr),
		.word_i       (dl_word_i),
		.flags_o      (hdr_flags),
		.hdr_ready_o  (hdr_ready)
	);

	region_select u_region_select (
		.clk_sys        (clk_sys),
		.sys_reset      (sys_reset),
		.cfg_i          (region_cfg_i),
		.cart_sms_i     (cart_sms_o),
		.index_i        (dl_index_i),
		.flags_i        (hdr_flags),
		.hdr_ready_i    (hdr_ready),
		.region_valid_o (region_valid_o),
		.region_o       (region_o),
		.region_ready_i (region_ready_i)
	);

	code_assembler u_code_assembler (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.code_start_i (code_start),
		.cart_start_i (cart_start),
		.in_valid_i   (code_in_valid),
		.word_i       (dl_word_i),
		.in_ready_o   (code_in_ready),
		.code_o       (code_o),
		.code_valid_o (code_valid_o),
		.code_ready_i (code_ready_i),
		.code_clear_o (code_clear_o)
	);

endmodule

/* src/dl_pkg.sv */
package dl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Stream geometry and index decode

	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	// Low five index bits of a cartridge download
	localparam logic [4:0] IDX_CART_MD  = 5'd1;
	localparam logic [4:0] IDX_CART_SMS = 5'd2;
	// Full index of a cheat file
	localparam logic [7:0] IDX_CODE     = 8'hFF;

	// Cartridge header bytes
	localparam logic [ADDR_W-1:0] HDR_REGION_ADDR  = 25'h1F0;
	localparam logic [ADDR_W-1:0] HDR_REGION2_ADDR = 25'h1F2;
	localparam logic [ADDR_W-1:0] HDR_END_ADDR     = 25'h200;

	// Cheat code layout, two bytes per word
	localparam int         CODE_WORDS    = 8;
	localparam logic [3:0] CODE_LAST_OFS = 4'(2 * (CODE_WORDS - 1));

	// Auto region modes, 2 and 3 disable
	localparam logic [1:0] AUTO_HEADER   = 2'd0;
	localparam logic [1:0] AUTO_FILE_EXT = 2'd1;

	////////////////////////////////////////////////////////////////////////////
	// Types

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} dl_word_t;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	// prio: 0 US>EU>JP, 1 EU>US>JP, 2 US>JP>EU, 3 JP>US>EU
	typedef struct packed {
		logic [1:0] auto_mode;
		logic [1:0] prio;
	} region_cfg_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

/* src/dl_router.sv */
`timescale 1ns/1ns

module dl_router (
	input  logic             clk_sys,
	input  logic             sys_reset,
	input  logic             dl_active_i,
	input  logic [7:0]       dl_index_i,
	input  logic             dl_valid_i,
	input  dl_pkg::dl_word_t dl_word_i,
	output logic             dl_ready_o,
	output logic             cart_sms_o,
	output logic             cart_start_o,
	output logic             cart_end_o,
	output logic             cart_wr_o,
	output logic             code_start_o,
	output logic             code_valid_o,
	input  logic             code_ready_i
);

	logic cart_dl;
	logic code_dl;
	logic cart_dl_q;
	logic code_dl_q;

	// Download class from the index
	assign cart_dl = dl_active_i &&
		(dl_index_i[4:0] == dl_pkg::IDX_CART_MD || dl_index_i[4:0] == dl_pkg::IDX_CART_SMS);
	assign code_dl = dl_active_i && (dl_index_i == dl_pkg::IDX_CODE);

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cart_dl_q  <= 1'b0;
			code_dl_q  <= 1'b0;
			cart_sms_o <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			code_dl_q <= code_dl;
			// Cart type sticks until the next cart download
			if (cart_start_o)
				cart_sms_o <= (dl_index_i[4:0] == dl_pkg::IDX_CART_SMS);
		end
	end

	assign cart_start_o = cart_dl & ~cart_dl_q;
	assign cart_end_o   = ~cart_dl & cart_dl_q;
	assign code_start_o = code_dl & ~code_dl_q;

	// Only the cheat path can stall the source
	assign dl_ready_o   = code_dl ? code_ready_i : 1'b1;
	assign cart_wr_o    = cart_dl & dl_valid_i & dl_ready_o;
	assign code_valid_o = code_dl & dl_valid_i;

	// 16-bit stream, so every accepted word sits on an even byte address
	a_word_aligned: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		(cart_wr_o || (code_valid_o && code_ready_i)) |-> !dl_word_i.addr[0]
	);

endmodule

/* src/header_scan.sv */
`timescale 1ns/1ns

module header_scan (
	input  logic               clk_sys,
	input  logic               sys_reset,
	input  logic               cart_start_i,
	input  logic               cart_end_i,
	input  logic               cart_wr_i,
	input  dl_pkg::dl_word_t   word_i,
	output dl_pkg::hdr_flags_t flags_o,
	output logic               hdr_ready_o
);

	dl_pkg::hdr_flags_t flags_nxt;
	logic [7:0]         lo_byte;
	logic [7:0]         hi_byte;
	logic [3:0]         hex_rgn;
	logic               at_region;
	logic               at_region2;

	// Letter J, U or E adds its flag, anything else leaves the set alone
	function automatic dl_pkg::hdr_flags_t add_letter(
		input dl_pkg::hdr_flags_t f,
		input logic [7:0]         c
	);
		dl_pkg::hdr_flags_t r;
		r = f;
		if (c == "J")
			r.j = 1'b1;
		else if (c == "U")
			r.u = 1'b1;
		else if (c == "E")
			r.e = 1'b1;
		return r;
	endfunction

	assign lo_byte    = word_i.data[7:0];
	assign hi_byte    = word_i.data[15:8];
	assign hex_rgn    = lo_byte[3:0] - 4'd7;
	assign at_region  = cart_wr_i && (word_i.addr == dl_pkg::HDR_REGION_ADDR);
	assign at_region2 = cart_wr_i && (word_i.addr == dl_pkg::HDR_REGION2_ADDR);

	////////////////////////////////////////////////////////////////////////////
	// Region byte decode

	always_comb begin
		flags_nxt = cart_start_i ? '0 : flags_o;
		if (at_region) begin
			if (lo_byte == "J" || lo_byte == "U" || lo_byte == "E") begin
				flags_nxt = add_letter(flags_nxt, lo_byte);
			end else if (lo_byte >= "0" && lo_byte <= "9") begin
				// New style region digit, one bit per market
				flags_nxt.e = lo_byte[3];
				flags_nxt.u = lo_byte[2];
				flags_nxt.j = lo_byte[0];
			end else if (lo_byte >= "A" && lo_byte <= "F") begin
				flags_nxt.e = hex_rgn[3];
				flags_nxt.u = hex_rgn[2];
				flags_nxt.j = hex_rgn[0];
			end
			flags_nxt = add_letter(flags_nxt, hi_byte);
		end
		if (at_region2)
			flags_nxt = add_letter(flags_nxt, lo_byte);
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			flags_o     <= '0;
			hdr_ready_o <= 1'b0;
		end else begin
			flags_o <= flags_nxt;
			// Header is complete once the first word past it arrives
			if (cart_end_i)
				hdr_ready_o <= 1'b0;
			else if (cart_wr_i && word_i.addr == dl_pkg::HDR_END_ADDR)
				hdr_ready_o <= 1'b1;
		end
	end

endmodule

/* src/region_select.sv */
`timescale 1ns/1ns

module region_select (
	input  logic                clk_sys,
	input  logic                sys_reset,
	input  dl_pkg::region_cfg_t cfg_i,
	input  logic                cart_sms_i,
	input  logic [7:0]          index_i,
	input  dl_pkg::hdr_flags_t  flags_i,
	input  logic                hdr_ready_i,
	output logic                region_valid_o,
	output dl_pkg::region_t     region_o,
	input  logic                region_ready_i
);

	logic            hdr_ready_q;
	logic            hdr_rise;
	logic            hdr_fall;
	logic            auto_on;
	logic            launch;
	dl_pkg::region_t hdr_region;
	dl_pkg::region_t pick;

	// First flag in priority order, else the order's leading region
	always_comb begin
		case (cfg_i.prio)
			2'd0: hdr_region = flags_i.u ? dl_pkg::US : flags_i.e ? dl_pkg::EU :
				flags_i.j ? dl_pkg::JP : dl_pkg::US;
			2'd1: hdr_region = flags_i.e ? dl_pkg::EU : flags_i.u ? dl_pkg::US :
				flags_i.j ? dl_pkg::JP : dl_pkg::EU;
			2'd2: hdr_region = flags_i.u ? dl_pkg::US : flags_i.j ? dl_pkg::JP :
				flags_i.e ? dl_pkg::EU : dl_pkg::US;
			default: hdr_region = flags_i.j ? dl_pkg::JP : flags_i.u ? dl_pkg::US :
				flags_i.e ? dl_pkg::EU : dl_pkg::JP;
		endcase
	end

	// File extension mode carries the region in the index top bits
	assign pick = (cfg_i.auto_mode == dl_pkg::AUTO_FILE_EXT) ?
		dl_pkg::region_t'(index_i[7:6]) : hdr_region;
	assign auto_on = (cfg_i.auto_mode == dl_pkg::AUTO_HEADER) ||
		(cfg_i.auto_mode == dl_pkg::AUTO_FILE_EXT);

	assign hdr_rise = hdr_ready_i & ~hdr_ready_q;
	assign hdr_fall = ~hdr_ready_i & hdr_ready_q;
	assign launch   = hdr_rise & auto_on & ~cart_sms_i;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			hdr_ready_q    <= 1'b0;
			region_valid_o <= 1'b0;
		end else begin
			hdr_ready_q <= hdr_ready_i;
			// Accepted, or the cart went away before anyone took it
			if (region_valid_o && (region_ready_i || hdr_fall))
				region_valid_o <= 1'b0;
			if (launch)
				region_valid_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (launch)
			region_o <= pick;
	end

	a_region_stable: assert property (
		@(posedge clk_sys) disable iff (sys_reset)
		(region_valid_o && !region_ready_i) |=> (!region_valid_o || $stable(region_o))
	);

endmodule
